//--- include/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Architectural register file seen by software.
`define ARCH_REGS 32
`define AREG_W 5

// Physical register pool behind the alias table.
`define PHYS_REGS 64
`define PREG_W 6

`endif

//--- rtl/rename_pkg.sv
`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

  typedef enum logic [3:0] {
    OP,
    OP_IMM,
    LOAD,
    STORE,
    BRANCH,
    JAL,
    JALR,
    LUI,
    UNKNOWN
  } opcode_e;

  // --------------------------------------------------------------------------
  // Stage 1 to stage 2
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [31:0]          pc;
    opcode_e              opcode;
    logic [`AREG_W-1:0]   rs1;
    logic [`AREG_W-1:0]   rs2;
    logic [`AREG_W-1:0]   rd;
    logic                 writes;
    logic                 jumps;
  } decoded_instr_t;

  typedef struct packed {
    decoded_instr_t [1:0] slot;
    logic                 valid;
  } decoded_pair_t;

  // --------------------------------------------------------------------------
  // Resolver and alias table
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [`AREG_W-1:0] rs1;
    logic [`AREG_W-1:0] rs2;
    logic [`AREG_W-1:0] rd;
    logic               alloc;
  } query_slot_t;

  typedef struct packed {
    query_slot_t [1:0] slot;
    logic              commit;
  } rename_query_t;

  typedef struct packed {
    logic [`PREG_W-1:0] prs1;
    logic [`PREG_W-1:0] prs2;
    logic [`PREG_W-1:0] new_preg;
  } reply_slot_t;

  typedef struct packed {
    reply_slot_t [1:0] slot;
    logic [6:0]        free_count;
  } rename_reply_t;

  // --------------------------------------------------------------------------
  // Renamed output
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [31:0]        pc;
    opcode_e            opcode;
    logic [`PREG_W-1:0] prs1;
    logic [`PREG_W-1:0] prs2;
    logic [`PREG_W-1:0] prd;
    logic [`AREG_W-1:0] rd;
    logic               writes;
    logic               jumps;
    logic               tag;
  } renamed_instr_t;

  typedef struct packed {
    renamed_instr_t [1:0] slot;
  } renamed_pair_t;

endpackage

`default_nettype wire

//--- rtl/pair_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pair_decoder (
  input  logic                     global_bus,
  input  logic                     reset,
  input  logic                     in_valid,
  input  logic [31:0]              in_pc,
  input  logic [63:0]              in_words,
  input  logic                     stall,
  input  logic                     hold,
  output rename_pkg::decoded_pair_t decoded
);

  function automatic rename_pkg::decoded_instr_t decode_word(input logic [31:0] word,
                                                             input logic [31:0] pc);
    rename_pkg::decoded_instr_t d;
    rename_pkg::opcode_e        op;
    logic                       use_rs1;
    logic                       use_rs2;
    case (word[6:0])
      7'b0110011: op = rename_pkg::OP;
      7'b0010011: op = rename_pkg::OP_IMM;
      7'b0000011: op = rename_pkg::LOAD;
      7'b0100011: op = rename_pkg::STORE;
      7'b1100011: op = rename_pkg::BRANCH;
      7'b1101111: op = rename_pkg::JAL;
      7'b1100111: op = rename_pkg::JALR;
      7'b0110111: op = rename_pkg::LUI;
      default:    op = rename_pkg::UNKNOWN;
    endcase
    use_rs1 = op inside {rename_pkg::OP, rename_pkg::OP_IMM, rename_pkg::LOAD,
                         rename_pkg::STORE, rename_pkg::BRANCH, rename_pkg::JALR};
    use_rs2 = op inside {rename_pkg::OP, rename_pkg::STORE, rename_pkg::BRANCH};
    d.pc     = pc;
    d.opcode = op;
    d.writes = !(op inside {rename_pkg::STORE, rename_pkg::BRANCH});
    d.jumps  = op inside {rename_pkg::BRANCH, rename_pkg::JAL, rename_pkg::JALR};
    d.rs1    = use_rs1 ? word[19:15] : '0;
    d.rs2    = use_rs2 ? word[24:20] : '0;
    // Store and branch reuse bits 11:7 for the immediate.
    d.rd     = d.writes ? word[11:7] : '0;
    return d;
  endfunction

  rename_pkg::decoded_instr_t [1:0] slot_d;
  rename_pkg::decoded_instr_t [1:0] slot_q;
  logic                             valid_q;
  logic                             load;

  assign slot_d[0] = decode_word(in_words[31:0], in_pc);
  assign slot_d[1] = decode_word(in_words[63:32], in_pc + 32'd4);

  // The stage moves only when the resolver takes the pair it holds.
  assign load = !stall && !hold;

  always_ff @(posedge global_bus) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= in_valid &&
                 slot_d[0].opcode != rename_pkg::UNKNOWN &&
                 slot_d[1].opcode != rename_pkg::UNKNOWN;
    end
  end

  always_ff @(posedge global_bus) begin
    if (load) begin
      slot_q <= slot_d;
    end
  end

  assign decoded.slot  = slot_q;
  assign decoded.valid = valid_q;

endmodule

`default_nettype wire

//--- rtl/rename_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rename_table (
  input  logic                      global_bus,
  input  logic                      reset,
  input  rename_pkg::rename_query_t query,
  output rename_pkg::rename_reply_t reply,
  input  logic                      free_valid,
  input  logic [`PREG_W-1:0]        free_preg
);

  logic [`PREG_W-1:0]    map_q [`ARCH_REGS];
  logic [`PHYS_REGS-1:0] free_q;
  logic [`PREG_W-1:0]    first_free;
  logic [`PREG_W-1:0]    second_free;
  logic [6:0]            free_count;
  logic [`PREG_W-1:0]    new_preg [2];

  // --------------------------------------------------------------------------
  // Lowest two free registers and the pool size
  // --------------------------------------------------------------------------
  always_comb begin
    free_count  = '0;
    first_free  = '0;
    second_free = '0;
    for (int i = 0; i < `PHYS_REGS; i++) begin
      if (free_q[i]) begin
        if (free_count == 7'd0) first_free = `PREG_W'(i);
        if (free_count == 7'd1) second_free = `PREG_W'(i);
        free_count = free_count + 7'd1;
      end
    end
  end

  // Slot 1 gets the lowest register when slot 0 takes none.
  assign new_preg[0] = first_free;
  assign new_preg[1] = query.slot[0].alloc ? second_free : first_free;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      reply.slot[s].prs1     = (query.slot[s].rs1 == '0) ? '0 : map_q[query.slot[s].rs1];
      reply.slot[s].prs2     = (query.slot[s].rs2 == '0) ? '0 : map_q[query.slot[s].rs2];
      reply.slot[s].new_preg = new_preg[s];
    end
    reply.free_count = free_count;
  end

  // --------------------------------------------------------------------------
  // State update
  // --------------------------------------------------------------------------
  always_ff @(posedge global_bus) begin
    if (reset) begin
      for (int i = 0; i < `ARCH_REGS; i++) begin
        map_q[i] <= `PREG_W'(i);
      end
      free_q <= {{(`PHYS_REGS - `ARCH_REGS){1'b1}}, {`ARCH_REGS{1'b0}}};
    end else begin
      if (free_valid) begin
        free_q[free_preg] <= 1'b1;
      end
      // Slot 1 is written last, so it wins on an equal rd.
      if (query.commit) begin
        for (int s = 0; s < 2; s++) begin
          if (query.slot[s].alloc) begin
            free_q[new_preg[s]]       <= 1'b0;
            map_q[query.slot[s].rd] <= new_preg[s];
          end
        end
      end
    end
  end

  free_legal_a: assert property (@(posedge global_bus) disable iff (reset)
    free_valid |-> (free_preg != '0 && !free_q[free_preg]));

  // The resolver's stall must keep commits within the free pool.
  commit_fits_a: assert property (@(posedge global_bus) disable iff (reset)
    query.commit |-> (7'(query.slot[0].alloc) + 7'(query.slot[1].alloc)) <= free_count);

endmodule

`default_nettype wire

//--- rtl/resolver.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module resolver (
  input  logic                      global_bus,
  input  logic                      reset,
  input  rename_pkg::decoded_pair_t decoded,
  input  logic                      hold,
  output logic                      stall,
  output rename_pkg::rename_query_t query,
  input  rename_pkg::rename_reply_t reply,
  output logic                      out_valid,
  output rename_pkg::renamed_pair_t out_pair
);

  function automatic logic depends(input logic [`AREG_W-1:0] rd,
                                   input logic [`AREG_W-1:0] rs);
    return rd != '0 && rd == rs;
  endfunction

  logic [1:0]                alloc;
  logic [6:0]                need;
  logic                      commit;
  rename_pkg::renamed_pair_t renamed;

  // --------------------------------------------------------------------------
  // Allocation demand and stall
  // --------------------------------------------------------------------------
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      alloc[s] = decoded.valid && decoded.slot[s].writes && decoded.slot[s].rd != '0;
    end
  end

  assign need   = 7'(alloc[0]) + 7'(alloc[1]);
  assign stall  = decoded.valid && (need > reply.free_count);
  assign commit = decoded.valid && !stall && !hold;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      query.slot[s].rs1   = decoded.slot[s].rs1;
      query.slot[s].rs2   = decoded.slot[s].rs2;
      query.slot[s].rd    = decoded.slot[s].rd;
      query.slot[s].alloc = alloc[s];
    end
    query.commit = commit;
  end

  // --------------------------------------------------------------------------
  // Renamed pair
  // --------------------------------------------------------------------------
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      renamed.slot[s].pc     = decoded.slot[s].pc;
      renamed.slot[s].opcode = decoded.slot[s].opcode;
      renamed.slot[s].prs1   = reply.slot[s].prs1;
      renamed.slot[s].prs2   = reply.slot[s].prs2;
      renamed.slot[s].prd    = alloc[s] ? reply.slot[s].new_preg : '0;
      renamed.slot[s].rd     = decoded.slot[s].rd;
      renamed.slot[s].writes = decoded.slot[s].writes;
      renamed.slot[s].jumps  = decoded.slot[s].jumps;
      renamed.slot[s].tag    = 1'b0;
    end
    // The table has not seen slot 0's write yet, so bypass it here.
    if (depends(decoded.slot[0].rd, decoded.slot[1].rs1)) begin
      renamed.slot[1].prs1 = reply.slot[0].new_preg;
    end
    if (depends(decoded.slot[0].rd, decoded.slot[1].rs2)) begin
      renamed.slot[1].prs2 = reply.slot[0].new_preg;
    end
    // Slot 1 is speculative behind a jump in slot 0.
    renamed.slot[1].tag = decoded.slot[0].jumps && !decoded.slot[1].jumps;
  end

  always_ff @(posedge global_bus) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (!hold) begin
      out_valid <= commit;
    end
  end

  always_ff @(posedge global_bus) begin
    if (commit) begin
      out_pair <= renamed;
    end
  end

  no_output_on_stall_a: assert property (@(posedge global_bus) disable iff (reset)
    (stall && !hold) |=> !out_valid);

endmodule

`default_nettype wire

//--- rtl/rename_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rename_top (
  input  logic                      global_bus,
  input  logic                      reset,
  input  logic                      in_valid,
  input  logic [31:0]               in_pc,
  input  logic [63:0]               in_words,
  input  logic                      hold,
  input  logic                      free_valid,
  input  logic [`PREG_W-1:0]        free_preg,
  output logic                      stall,
  output logic                      out_valid,
  output rename_pkg::renamed_pair_t out_pair
);

  rename_pkg::decoded_pair_t decoded;
  rename_pkg::rename_query_t query;
  rename_pkg::rename_reply_t reply;

  pair_decoder u_decoder (
    .global_bus (global_bus),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_pc      (in_pc),
    .in_words   (in_words),
    .stall      (stall),
    .hold       (hold),
    .decoded    (decoded)
  );

  resolver u_resolver (
    .global_bus (global_bus),
    .reset      (reset),
    .decoded    (decoded),
    .hold       (hold),
    .stall      (stall),
    .query      (query),
    .reply      (reply),
    .out_valid  (out_valid),
    .out_pair   (out_pair)
  );

  rename_table u_table (
    .global_bus (global_bus),
    .reset      (reset),
    .query      (query),
    .reply      (reply),
    .free_valid (free_valid),
    .free_preg  (free_preg)
  );

endmodule

`default_nettype wire

//--- dv/rename_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rename_tb;

  logic                      global_bus;
  logic                      reset;
  logic                      in_valid;
  logic [31:0]               in_pc;
  logic [63:0]               in_words;
  logic                      hold;
  logic                      free_valid;
  logic [`PREG_W-1:0]        free_preg;
  logic                      stall;
  logic                      out_valid;
  rename_pkg::renamed_pair_t out_pair;

  // Reference alias model and expected output.
  rename_pkg::renamed_pair_t exp_pair;
  logic                      expect_out;
  logic [`PREG_W-1:0]        model_map [`ARCH_REGS];
  logic [`PHYS_REGS-1:0]     model_free;
  logic [`PREG_W-1:0]        in_use [$];
  logic [6:0]                legal_ops [8];
  logic [31:0]               lcg_state;
  logic                      hold_enable;
  logic                      hold_seen;
  int                        cycle;

  rename_top uut (
    .global_bus (global_bus),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_pc      (in_pc),
    .in_words   (in_words),
    .hold       (hold),
    .free_valid (free_valid),
    .free_preg  (free_preg),
    .stall      (stall),
    .out_valid  (out_valid),
    .out_pair   (out_pair)
  );

  initial begin
    global_bus = 1'b0;
    forever #20 global_bus = ~global_bus;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  function automatic rename_pkg::opcode_e op_of(input logic [31:0] w);
    case (w[6:0])
      7'b0110011: return rename_pkg::OP;
      7'b0010011: return rename_pkg::OP_IMM;
      7'b0000011: return rename_pkg::LOAD;
      7'b0100011: return rename_pkg::STORE;
      7'b1100011: return rename_pkg::BRANCH;
      7'b1101111: return rename_pkg::JAL;
      7'b1100111: return rename_pkg::JALR;
      7'b0110111: return rename_pkg::LUI;
      default:    return rename_pkg::UNKNOWN;
    endcase
  endfunction

  function automatic int free_total();
    int n;
    n = 0;
    for (int i = 0; i < `PHYS_REGS; i++) begin
      if (model_free[i]) n++;
    end
    return n;
  endfunction

  function automatic logic [`PREG_W-1:0] lowest_free();
    for (int i = 0; i < `PHYS_REGS; i++) begin
      if (model_free[i]) return `PREG_W'(i);
    end
    return '0;
  endfunction

  task automatic field_check(input int s, input string name,
                             input logic [31:0] got, input logic [31:0] exp);
    if (got != exp) begin
      fail_now($sformatf("[FAIL] out_pair.slot[%0d].%s got %h expected %h",
                         s, name, got, exp));
    end
  endtask

  task automatic report_mismatch();
    for (int s = 0; s < 2; s++) begin
      field_check(s, "pc", out_pair.slot[s].pc, exp_pair.slot[s].pc);
      field_check(s, "opcode", 32'(out_pair.slot[s].opcode), 32'(exp_pair.slot[s].opcode));
      field_check(s, "prs1", 32'(out_pair.slot[s].prs1), 32'(exp_pair.slot[s].prs1));
      field_check(s, "prs2", 32'(out_pair.slot[s].prs2), 32'(exp_pair.slot[s].prs2));
      field_check(s, "prd", 32'(out_pair.slot[s].prd), 32'(exp_pair.slot[s].prd));
      field_check(s, "rd", 32'(out_pair.slot[s].rd), 32'(exp_pair.slot[s].rd));
      field_check(s, "writes", 32'(out_pair.slot[s].writes), 32'(exp_pair.slot[s].writes));
      field_check(s, "jumps", 32'(out_pair.slot[s].jumps), 32'(exp_pair.slot[s].jumps));
      field_check(s, "tag", 32'(out_pair.slot[s].tag), 32'(exp_pair.slot[s].tag));
    end
    fail_now("out_pair differs from the expected pair");
  endtask

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  reset_quiet_a: assert property (@(posedge global_bus) $past(reset) |-> !out_valid && !stall)
    else fail_now("out_valid or stall high during or right after reset");
  out_match_a: assert property (@(posedge global_bus) disable iff (reset)
    out_valid |-> out_pair == exp_pair) else report_mismatch();
  out_expected_a: assert property (@(posedge global_bus) disable iff (reset)
    out_valid |-> expect_out) else fail_now("out_valid rose with no renamed pair pending");
  hold_pair_a: assert property (@(posedge global_bus) disable iff (reset)
    hold |=> $stable(out_pair)) else fail_now("out_pair changed while hold was high");
  hold_valid_a: assert property (@(posedge global_bus) disable iff (reset)
    hold |=> $stable(out_valid)) else fail_now("out_valid changed while hold was high");

  // One clock cycle, with a fresh random hold level driven after the edge.
  task automatic tick();
    if (hold) hold_seen = 1'b1;
    @(posedge global_bus);
    #2;
    cycle++;
    hold = hold_enable && (lcg_next() % 6 == 0);
  endtask

  task automatic send_pair(input logic [31:0] pc, input logic [31:0] w0,
                           input logic [31:0] w1);
    rename_pkg::opcode_e op [2];
    logic [31:0]         w [2];
    logic [`AREG_W-1:0]  rs1 [2];
    logic [`AREG_W-1:0]  rs2 [2];
    logic [`AREG_W-1:0]  rd [2];
    logic [`PREG_W-1:0]  prd [2];
    int                  need;
    int                  waited;
    int                  accept_cycle;
    logic                accepted;
    logic                delayed;
    w[0] = w0;
    w[1] = w1;
    for (int s = 0; s < 2; s++) begin
      op[s]  = op_of(w[s]);
      rs1[s] = (op[s] inside {rename_pkg::OP, rename_pkg::OP_IMM, rename_pkg::LOAD,
               rename_pkg::STORE, rename_pkg::BRANCH, rename_pkg::JALR}) ? w[s][19:15] : '0;
      rs2[s] = (op[s] inside {rename_pkg::OP, rename_pkg::STORE, rename_pkg::BRANCH})
               ? w[s][24:20] : '0;
      rd[s]  = (op[s] inside {rename_pkg::STORE, rename_pkg::BRANCH}) ? '0 : w[s][11:7];
    end
    in_pc        = pc;
    in_words     = {w1, w0};
    in_valid     = 1'b1;
    waited       = 0;
    accepted     = 1'b0;
    accept_cycle = 0;
    while (!accepted) begin
      accepted     = !hold && !stall;
      accept_cycle = cycle;
      tick();
      waited++;
      if (waited > 40) fail_now("timeout: fetched pair was never accepted");
    end
    in_valid     = 1'b0;
    hold_seen    = 1'b0;
    if (op[0] == rename_pkg::UNKNOWN || op[1] == rename_pkg::UNKNOWN) begin
      repeat (4) tick();
      return;
    end
    need    = int'(rd[0] != '0) + int'(rd[1] != '0);
    delayed = 1'b0;
    if (need > free_total()) begin
      delayed = 1'b1;
      stall_seen_a: assert (stall) else fail_now("stall stayed low with the pool exhausted");
      while (need > free_total()) begin
        if (in_use.size() == 0) fail_now("no allocated register left to free");
        free_preg  = in_use.pop_front();
        free_valid = 1'b1;
        model_free[free_preg] = 1'b1;
        tick();
        free_valid = 1'b0;
      end
    end
    for (int s = 0; s < 2; s++) begin
      exp_pair.slot[s].pc     = pc + 32'(4 * s);
      exp_pair.slot[s].opcode = op[s];
      exp_pair.slot[s].prs1   = (rs1[s] == '0) ? '0 : model_map[rs1[s]];
      exp_pair.slot[s].prs2   = (rs2[s] == '0) ? '0 : model_map[rs2[s]];
      exp_pair.slot[s].rd     = rd[s];
      exp_pair.slot[s].writes = !(op[s] inside {rename_pkg::STORE, rename_pkg::BRANCH});
      exp_pair.slot[s].jumps  = op[s] inside {rename_pkg::BRANCH, rename_pkg::JAL,
                                              rename_pkg::JALR};
      exp_pair.slot[s].tag    = 1'b0;
    end
    for (int s = 0; s < 2; s++) begin
      prd[s] = (rd[s] != '0) ? lowest_free() : '0;
      exp_pair.slot[s].prd = prd[s];
      if (rd[s] != '0) begin
        model_free[prd[s]] = 1'b0;
        in_use.push_back(prd[s]);
      end
    end
    if (rd[0] != '0 && rd[0] == rs1[1]) exp_pair.slot[1].prs1 = prd[0];
    if (rd[0] != '0 && rd[0] == rs2[1]) exp_pair.slot[1].prs2 = prd[0];
    exp_pair.slot[1].tag = exp_pair.slot[0].jumps && !exp_pair.slot[1].jumps;
    // Slot 1 updates the map last, so it wins on an equal rd.
    for (int s = 0; s < 2; s++) begin
      if (rd[s] != '0) model_map[rd[s]] = prd[s];
    end
    expect_out = 1'b1;
    waited = 0;
    while (!out_valid) begin
      tick();
      waited++;
      if (waited > 60) fail_now("timeout: renamed pair never reached the output");
    end
    if (!delayed && !hold_seen) begin
      latency_a: assert (cycle - accept_cycle == 2)
        else fail_now("out_valid did not come two cycles after acceptance");
    end
    waited = 0;
    while (out_valid) begin
      tick();
      waited++;
      if (waited > 60) fail_now("timeout: out_valid never dropped");
    end
    expect_out = 1'b0;
  endtask

  function automatic logic [31:0] make_word();
    logic [31:0] r;
    logic [31:0] f;
    r = lcg_next();
    f = lcg_next();
    if (r[31:28] == 4'd0) return {f[31:7], 7'b0001111};
    return {f[31:7], legal_ops[r[26:24]]};
  endfunction

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] pc;
    logic [31:0] w0;
    logic [31:0] w1;
    lcg_state   = 32'h888a;
    reset       = 1'b1;
    in_valid    = 1'b0;
    in_pc       = '0;
    in_words    = '0;
    hold        = 1'b0;
    free_valid  = 1'b0;
    free_preg   = '0;
    hold_enable = 1'b0;
    hold_seen   = 1'b0;
    expect_out  = 1'b0;
    exp_pair    = '0;
    cycle       = 0;
    legal_ops[0] = 7'b0110011;
    legal_ops[1] = 7'b0010011;
    legal_ops[2] = 7'b0000011;
    legal_ops[3] = 7'b0100011;
    legal_ops[4] = 7'b1100011;
    legal_ops[5] = 7'b1101111;
    legal_ops[6] = 7'b1100111;
    legal_ops[7] = 7'b0110111;
    for (int i = 0; i < `ARCH_REGS; i++) model_map[i] = `PREG_W'(i);
    model_free = {{(`PHYS_REGS - `ARCH_REGS){1'b1}}, {`ARCH_REGS{1'b0}}};
    repeat (4) @(posedge global_bus);
    #2;
    reset = 1'b0;
    repeat (2) tick();
    hold_enable = 1'b1;
    pc = 32'h1000;
    for (int n = 0; n < 80; n++) begin
      w0 = make_word();
      w1 = make_word();
      // Bias slot 1 toward reading or rewriting slot 0's destination.
      if (lcg_next() % 4 == 0) w1[19:15] = w0[11:7];
      if (lcg_next() % 5 == 0) w1[11:7] = w0[11:7];
      send_pair(pc, w0, w1);
      pc = pc + 32'd8;
    end
    hold_enable = 1'b0;
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
rtl/rename_pkg.sv
rtl/pair_decoder.sv
rtl/rename_table.sv
rtl/resolver.sv
rtl/rename_top.sv
dv/rename_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the rename front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f all.f \
  --top-module rename_tb \
  -Mdir obj_dir \
  -o rename_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit $status
fi

./obj_dir/rename_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
